// ==== Bender.yml ====
package:
  name: m68k_alu

sources:
  - hdl/alu_ops_pkg.sv
  - hdl/alu_flags_pkg.sv
  - hdl/alu_arith.sv
  - hdl/alu_shift.sv
  - hdl/alu_divider.sv
  - hdl/alu_result_reg.sv
  - hdl/alu_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/alu_tb.sv

// ==== hdl/alu_arith.sv ====
// Logic, add, subtract, compare, extended and move results
// Size-aware condition flags for these operations
`timescale 1ns/1ps

module alu_arith
    import alu_ops_pkg::*;
    import alu_flags_pkg::*;
(
    input  alu_req_t      req,
    input  alu_ccr_t      ccr,
    output alu_unit_out_t out
);

    logic              extended;
    logic              x_in;
    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic [DATA_W-1:0] res;
    logic              sm;
    logic              dm;
    logic              rm;
    logic              res_zero;
    logic              zero_flag;

    // ADDX and SUBX take X as carry or borrow in
    assign extended = (req.op == ADDX) || (req.op == SUBX);
    assign x_in     = extended ? ccr.x : 1'b0;
    assign sum      = req.operand1 + req.operand2 + DATA_W'(x_in);
    assign diff     = req.operand1 - req.operand2 - DATA_W'(x_in);

    always_comb begin
        case (req.op)
            OR:             res = req.operand1 | req.operand2;
            AND:            res = req.operand1 & req.operand2;
            EOR:            res = req.operand1 ^ req.operand2;
            ADD, ADDX:      res = sum;
            SUB, SUBX, CMP: res = diff;
            default:        res = req.operand1;
        endcase
    end

    assign sm       = size_msb(req.operand2, req.size);
    assign dm       = size_msb(req.operand1, req.size);
    assign rm       = size_msb(res, req.size);
    assign res_zero = size_zero(res, req.size);

    // Multi-precision chains may only clear Z
    assign zero_flag = extended ? (ccr.z & res_zero) : res_zero;

    always_comb begin
        out.result.long_word = res;
        out.ccr              = ccr;
        case (req.op)
            OR, AND, EOR, MOVE: begin
                out.ccr.n = rm;
                out.ccr.z = res_zero;
                out.ccr.v = 1'b0;
                out.ccr.c = 1'b0;
            end
            ADD, ADDX: begin
                out.ccr.n = rm;
                out.ccr.z = zero_flag;
                out.ccr.v = (sm & dm & ~rm) | (~sm & ~dm & rm);
                out.ccr.c = (sm & dm) | (~rm & dm) | (sm & ~rm);
                out.ccr.x = out.ccr.c;
            end
            SUB, SUBX, CMP: begin
                out.ccr.n = rm;
                out.ccr.z = zero_flag;
                out.ccr.v = (~sm & dm & ~rm) | (sm & ~dm & rm);
                out.ccr.c = (sm & ~dm) | (rm & ~dm) | (sm & rm);
                // Compare keeps X
                if (req.op != CMP) begin
                    out.ccr.x = out.ccr.c;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/alu_divider.sv ====
// Sequential restoring 32/16 divider, signed and unsigned
// Overflow and zero-divisor detection at collect and request
`timescale 1ns/1ps

module alu_divider
    import alu_ops_pkg::*;
    import alu_flags_pkg::*;
(
    input  logic            clock,
    input  logic            reset_n,
    input  alu_req_t        req,
    output alu_div_status_t status,
    output logic            div_ready
);

    localparam int              CNT_W     = $clog2(DIV_STEPS + 2);
    localparam logic [CNT_W-1:0] CNT_START = CNT_W'(DIV_STEPS + 1);
    localparam logic [HALF_W-1:0] NEG_LIMIT = HALF_W'(1) << (HALF_W - 1);

    logic [CNT_W-1:0]  count;
    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] dvs_q;
    logic [HALF_W:0]   quo_q;
    logic              signed_q;
    logic              quo_neg_q;
    logic              rem_neg_q;
    logic              div_req;
    logic              idle;
    logic              waiting;
    logic              zero_divisor;
    logic              start;
    logic              collect;
    logic [DATA_W:0]   diff;
    logic [HALF_W-1:0] divisor;
    logic              overflow;

    assign div_req      = req.op == DIV;
    assign idle         = count == '0;
    assign waiting      = count == CNT_W'(1);
    assign div_ready    = idle || waiting;
    assign divisor      = req.operand2[HALF_W-1:0];
    assign zero_divisor = divisor == '0;
    assign start        = div_req && idle && !zero_divisor;
    assign collect      = div_req && waiting;
    // Bit DATA_W set means a borrow
    assign diff         = {1'b0, rem_q} - {1'b0, dvs_q};

    // 0 idle, 1 result waiting, above 1 iterating
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_START;
        end else if (count > CNT_W'(1)) begin
            count <= count - CNT_W'(1);
        end else if (collect) begin
            count <= '0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            signed_q  <= req.div_signed;
            quo_neg_q <= req.div_signed & (req.operand1[DATA_W-1] ^ divisor[HALF_W-1]);
            rem_neg_q <= req.div_signed & req.operand1[DATA_W-1];
            rem_q     <= (req.div_signed && req.operand1[DATA_W-1]) ? -req.operand1
                                                                    : req.operand1;
            dvs_q     <= (req.div_signed && divisor[HALF_W-1]) ? {-divisor, HALF_W'(0)}
                                                               : {divisor, HALF_W'(0)};
            quo_q     <= '0;
        end else if (count > CNT_W'(1)) begin
            if (!diff[DATA_W]) begin
                rem_q <= diff[DATA_W-1:0];
                quo_q <= {quo_q[HALF_W-1:0], 1'b1};
            end else begin
                quo_q <= {quo_q[HALF_W-1:0], 1'b0};
            end
            dvs_q <= dvs_q >> 1;
        end
    end

    // Quotient beyond 16 bits, or beyond the signed range for DIVS
    assign overflow = quo_q[HALF_W]
                    | (signed_q & (quo_neg_q ? (quo_q[HALF_W-1:0] > NEG_LIMIT)
                                             : quo_q[HALF_W-1]));

    always_comb begin
        status                      = '0;
        status.zero_div             = div_req && idle && zero_divisor;
        status.overflow             = collect && overflow;
        status.done                 = collect || status.zero_div;
        status.trap                 = status.zero_div || status.overflow;
        status.result.div.quotient  = quo_neg_q ? -quo_q[HALF_W-1:0] : quo_q[HALF_W-1:0];
        status.result.div.remainder = rem_neg_q ? -rem_q[HALF_W-1:0] : rem_q[HALF_W-1:0];
    end

    a_count_range: assert property (
        @(posedge clock) disable iff (!reset_n) count <= CNT_START
    );

    a_done_when_ready: assert property (
        @(posedge clock) disable iff (!reset_n) status.done |-> div_ready
    );

endmodule

// ==== hdl/alu_flags_pkg.sv ====
// Condition flags, unit output and division status types
// Result word with its long and quotient/remainder views
package alu_flags_pkg;

    import alu_ops_pkg::*;

    typedef struct packed {
        logic x;
        logic n;
        logic z;
        logic v;
        logic c;
    } alu_ccr_t;

    // Division view of the result word
    typedef struct packed {
        logic [HALF_W-1:0] remainder;
        logic [HALF_W-1:0] quotient;
    } alu_div_word_t;

    typedef union packed {
        logic [DATA_W-1:0] long_word;
        alu_div_word_t     div;
    } alu_result_u;

    typedef struct packed {
        alu_result_u result;
        alu_ccr_t    ccr;
    } alu_unit_out_t;

    typedef struct packed {
        logic        done;
        logic        trap;
        logic        overflow;
        logic        zero_div;
        alu_result_u result;
    } alu_div_status_t;

endpackage

// ==== hdl/alu_ops_pkg.sv ====
// Operation codes, operand sizes and the request struct of the ALU
// Architectural widths and size-aware bit helpers
package alu_ops_pkg;

    localparam int DATA_W    = 32;
    localparam int HALF_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int DIV_STEPS = 17;

    typedef enum logic [4:0] {
        NOP,
        OR,
        AND,
        EOR,
        ADD,
        SUB,
        CMP,
        ADDX,
        SUBX,
        MOVE,
        ASL,
        LSL,
        ROL,
        ROXL,
        ASR,
        LSR,
        ROR,
        ROXR,
        DIV
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        WORD = 2'd1,
        LONG = 2'd2
    } alu_size_e;

    // operand1 is the destination or dividend, operand2 the source or divisor
    typedef struct packed {
        alu_op_e           op;
        alu_size_e         size;
        logic              div_signed;
        logic [DATA_W-1:0] operand1;
        logic [DATA_W-1:0] operand2;
    } alu_req_t;

    // Top bit of a value at the request size
    function automatic logic size_msb(input logic [DATA_W-1:0] data, input alu_size_e size);
        case (size)
            BYTE:    return data[BYTE_W-1];
            WORD:    return data[HALF_W-1];
            default: return data[DATA_W-1];
        endcase
    endfunction

    // Zero test limited to the bits of the size
    function automatic logic size_zero(input logic [DATA_W-1:0] data, input alu_size_e size);
        case (size)
            BYTE:    return data[BYTE_W-1:0] == '0;
            WORD:    return data[HALF_W-1:0] == '0;
            default: return data == '0;
        endcase
    endfunction

endpackage

// ==== hdl/alu_result_reg.sv ====
// Result, condition flag and division trap registers
// Selects the producing unit by operation code
`timescale 1ns/1ps

module alu_result_reg
    import alu_ops_pkg::*;
    import alu_flags_pkg::*;
(
    input  logic              clock,
    input  logic              reset_n,
    input  alu_req_t          req,
    input  alu_unit_out_t     arith_out,
    input  alu_unit_out_t     shift_out,
    input  alu_div_status_t   div_status,
    output logic [DATA_W-1:0] result,
    output alu_ccr_t          ccr,
    output logic              div_trap
);

    alu_ccr_t          div_ccr;
    logic [HALF_W-1:0] quotient;

    assign quotient = div_status.result.long_word[HALF_W-1:0];

    // Division flags, X untouched
    always_comb begin
        div_ccr = ccr;
        if (div_status.zero_div) begin
            div_ccr.n = 1'b0;
            div_ccr.z = 1'b0;
            div_ccr.v = 1'b0;
            div_ccr.c = 1'b0;
        end else if (div_status.overflow) begin
            div_ccr.n = 1'b1;
            div_ccr.z = 1'b0;
            div_ccr.v = 1'b1;
            div_ccr.c = 1'b0;
        end else begin
            div_ccr.n = quotient[HALF_W-1];
            div_ccr.z = quotient == '0;
            div_ccr.v = 1'b0;
            div_ccr.c = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            result   <= '0;
            ccr      <= '0;
            div_trap <= 1'b0;
        end else begin
            case (req.op)
                OR, AND, EOR, ADD, SUB, ADDX, SUBX, MOVE: begin
                    result <= arith_out.result.long_word;
                    ccr    <= arith_out.ccr;
                end
                // Compare sets flags only
                CMP: ccr <= arith_out.ccr;
                ASL, LSL, ROL, ROXL, ASR, LSR, ROR, ROXR: begin
                    result <= shift_out.result.long_word;
                    ccr    <= shift_out.ccr;
                end
                DIV: begin
                    if (div_status.done) begin
                        div_trap <= div_status.trap;
                        ccr      <= div_ccr;
                        // Failed division keeps the old result
                        if (!div_status.trap) begin
                            result <= div_status.result.long_word;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    a_trap_on_done: assert property (
        @(posedge clock) disable iff (!reset_n) $changed(div_trap) |-> $past(div_status.done)
    );

endmodule

// ==== hdl/alu_shift.sv ====
// One-bit shifts and rotates with fill at the operand size
// C, X and V follow the left and right shift rules
`timescale 1ns/1ps

module alu_shift
    import alu_ops_pkg::*;
    import alu_flags_pkg::*;
(
    input  alu_req_t      req,
    input  alu_ccr_t      ccr,
    output alu_unit_out_t out
);

    logic              shift_left;
    logic              shift_right;
    logic              dm;
    logic              lbit;
    logic              rbit;
    logic [DATA_W-1:0] res;
    logic              rm;

    assign shift_left  = (req.op == ASL) || (req.op == LSL) || (req.op == ROL) || (req.op == ROXL);
    assign shift_right = (req.op == ASR) || (req.op == LSR) || (req.op == ROR) || (req.op == ROXR);
    assign dm          = size_msb(req.operand1, req.size);

    // Entry bits, zero for the logical shifts
    assign lbit = ((req.op == ROL) & dm) | ((req.op == ROXL) & ccr.x);
    assign rbit = ((req.op == ASR) & dm) | ((req.op == ROR) & req.operand1[0])
                | ((req.op == ROXR) & ccr.x);

    always_comb begin
        if (shift_left) begin
            res = {req.operand1[DATA_W-2:0], lbit};
        end else begin
            res = {1'b0, req.operand1[DATA_W-1:1]};
            // Right fill lands on the top bit of the size
            case (req.size)
                BYTE:    res[BYTE_W-1] = rbit;
                WORD:    res[HALF_W-1] = rbit;
                default: res[DATA_W-1] = rbit;
            endcase
        end
    end

    assign rm = size_msb(res, req.size);

    always_comb begin
        out.result.long_word = res;
        out.ccr              = ccr;
        if (shift_left) begin
            out.ccr.c = dm;
            out.ccr.v = (req.op == ASL) ? (rm ^ dm) : 1'b0;
            if (req.op != ROL) begin
                out.ccr.x = dm;
            end
        end else if (shift_right) begin
            out.ccr.c = req.operand1[0];
            out.ccr.v = 1'b0;
            if (req.op != ROR) begin
                out.ccr.x = req.operand1[0];
            end
        end
        if (shift_left || shift_right) begin
            out.ccr.n = rm;
            out.ccr.z = size_zero(res, req.size);
        end
    end

endmodule

// ==== hdl/alu_top.sv ====
// ALU top level with arithmetic, shift and divider units
// Result and flag registers feed the flags back to the units
`timescale 1ns/1ps

module alu_top
    import alu_ops_pkg::*;
    import alu_flags_pkg::*;
(
    input  logic              clock,
    input  logic              reset_n,
    input  alu_req_t          req,
    output logic [DATA_W-1:0] result,
    output alu_ccr_t          ccr,
    output logic              div_trap,
    output logic              div_ready
);

    alu_unit_out_t   arith_out;
    alu_unit_out_t   shift_out;
    alu_div_status_t div_status;

    alu_arith u_arith (
        .req (req),
        .ccr (ccr),
        .out (arith_out)
    );

    alu_shift u_shift (
        .req (req),
        .ccr (ccr),
        .out (shift_out)
    );

    alu_divider u_div (
        .clock     (clock),
        .reset_n   (reset_n),
        .req       (req),
        .status    (div_status),
        .div_ready (div_ready)
    );

    alu_result_reg u_result (
        .clock      (clock),
        .reset_n    (reset_n),
        .req        (req),
        .arith_out  (arith_out),
        .shift_out  (shift_out),
        .div_status (div_status),
        .result     (result),
        .ccr        (ccr),
        .div_trap   (div_trap)
    );

endmodule

// ==== m68k_alu.f ====
hdl/alu_ops_pkg.sv
hdl/alu_flags_pkg.sv
hdl/alu_arith.sv
hdl/alu_shift.sv
hdl/alu_divider.sv
hdl/alu_result_reg.sv
hdl/alu_top.sv
verif/tb_clock_gen.sv
verif/alu_tb.sv

// ==== verif/alu_tb.sv ====
// ALU testbench with a reference model of flags, shifts and division
// Random stimulus, typed compare tasks and a cycle-count timeout
`timescale 1ns/1ps

module alu_tb
    import alu_ops_pkg::*;
    import alu_flags_pkg::*;
();

    localparam int RAND_OPS    = 300;
    localparam int SHIFT_REPS  = 4;
    localparam int CHAIN_OPS   = 16;
    localparam int RAND_DIVS   = 40;
    localparam int FIXED_DIVS  = 5;
    localparam int OP_COUNT    = RAND_OPS + 8 * 3 * SHIFT_REPS + CHAIN_OPS;
    localparam int CYCLE_LIMIT = 2 * (OP_COUNT + 20 * (RAND_DIVS + FIXED_DIVS));

    logic              clock;
    logic              reset_n;
    alu_req_t          req;
    logic [DATA_W-1:0] result;
    alu_ccr_t          ccr;
    logic              div_trap;
    logic              div_ready;

    // Expected state of the model
    alu_result_u exp_result;
    alu_ccr_t    exp_ccr;
    logic        exp_trap;
    int          cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    alu_top dut0 (
        .clock     (clock),
        .reset_n   (reset_n),
        .req       (req),
        .result    (result),
        .ccr       (ccr),
        .div_trap  (div_trap),
        .div_ready (div_ready)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                CYCLE_LIMIT));
        end
    end

    task automatic check_result(input string what, input alu_result_u got,
                                input alu_result_u want);
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t: %s result got %h expected %h",
                                $time, what, got, want));
        end
    endtask

    task automatic check_ccr(input string what, input alu_ccr_t got, input alu_ccr_t want);
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t: %s flags XNZVC got %b expected %b",
                                $time, what, got, want));
        end
    endtask

    task automatic check_trap(input string what, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t: %s div_trap got %b expected %b",
                                $time, what, got, want));
        end
    endtask

    task automatic check_ready(input string what, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t: %s div_ready got %b expected %b",
                                $time, what, got, want));
        end
    endtask

    task automatic check_outputs(input string what);
        check_result(what, result, exp_result);
        check_ccr(what, ccr, exp_ccr);
        check_trap(what, div_trap, exp_trap);
    endtask

    function automatic int size_bits(input alu_size_e size);
        case (size)
            BYTE:    return 8;
            WORD:    return 16;
            default: return 32;
        endcase
    endfunction

    function automatic alu_req_t make_req(input alu_op_e op, input alu_size_e size,
                                          input logic sgn, input logic [DATA_W-1:0] a,
                                          input logic [DATA_W-1:0] b);
        alu_req_t r;
        r.op         = op;
        r.size       = size;
        r.div_signed = sgn;
        r.operand1   = a;
        r.operand2   = b;
        return r;
    endfunction

    // Any operation from OR up to ROXR
    function automatic alu_req_t random_req();
        alu_req_t r;
        r = make_req(alu_op_e'($urandom_range(int'(OR), int'(ROXR))),
                     alu_size_e'($urandom_range(0, 2)), 1'b0, $urandom(), $urandom());
        // Equal operands now and then, for zero results
        if ($urandom_range(0, 3) == 0) begin
            r.operand2 = r.operand1;
        end
        return r;
    endfunction

    // Model of one non-division operation
    task automatic model_step(input alu_req_t r);
        int                w;
        logic [DATA_W-1:0] mask;
        logic [DATA_W:0]   wide;
        logic [DATA_W-1:0] res;
        logic              xin;
        logic              dm;
        logic              sm;
        logic              rm;
        logic              zero;
        logic              carry;
        w     = size_bits(r.size);
        mask  = (w == DATA_W) ? {DATA_W{1'b1}} : ((DATA_W'(1) << w) - DATA_W'(1));
        dm    = r.operand1[w-1];
        sm    = r.operand2[w-1];
        xin   = (r.op == ADDX || r.op == SUBX) ? exp_ccr.x : 1'b0;
        carry = 1'b0;
        res   = r.operand1;
        case (r.op)
            OR:  res = r.operand1 | r.operand2;
            AND: res = r.operand1 & r.operand2;
            EOR: res = r.operand1 ^ r.operand2;
            ADD, ADDX: begin
                res   = r.operand1 + r.operand2 + DATA_W'(xin);
                wide  = {1'b0, r.operand1 & mask} + {1'b0, r.operand2 & mask}
                      + (DATA_W+1)'(xin);
                carry = wide[w];
            end
            SUB, SUBX, CMP: begin
                res   = r.operand1 - r.operand2 - DATA_W'(xin);
                // Borrow when source plus X exceeds the destination at the size
                carry = {1'b0, r.operand1 & mask} < ({1'b0, r.operand2 & mask}
                                                     + (DATA_W+1)'(xin));
            end
            ASL, LSL: res = r.operand1 << 1;
            ROL:      res = {r.operand1[DATA_W-2:0], dm};
            ROXL:     res = {r.operand1[DATA_W-2:0], exp_ccr.x};
            ASR, LSR, ROR, ROXR: begin
                res = r.operand1 >> 1;
                case (r.op)
                    ASR:     res[w-1] = dm;
                    LSR:     res[w-1] = 1'b0;
                    ROR:     res[w-1] = r.operand1[0];
                    default: res[w-1] = exp_ccr.x;
                endcase
            end
            default: ;
        endcase
        rm   = res[w-1];
        zero = (res & mask) == '0;
        case (r.op)
            OR, AND, EOR, MOVE: begin
                exp_ccr.n = rm;
                exp_ccr.z = zero;
                exp_ccr.v = 1'b0;
                exp_ccr.c = 1'b0;
            end
            ADD, ADDX, SUB, SUBX, CMP: begin
                exp_ccr.n = rm;
                exp_ccr.z = (r.op == ADDX || r.op == SUBX) ? (exp_ccr.z & zero) : zero;
                exp_ccr.c = carry;
                if (r.op == ADD || r.op == ADDX) begin
                    exp_ccr.v = (sm == dm) && (rm != dm);
                end else begin
                    exp_ccr.v = (sm != dm) && (rm != dm);
                end
                if (r.op != CMP) begin
                    exp_ccr.x = carry;
                end
            end
            ASL, LSL, ROL, ROXL: begin
                exp_ccr.n = rm;
                exp_ccr.z = zero;
                exp_ccr.c = dm;
                exp_ccr.v = (r.op == ASL) && (rm != dm);
                if (r.op != ROL) begin
                    exp_ccr.x = dm;
                end
            end
            ASR, LSR, ROR, ROXR: begin
                exp_ccr.n = rm;
                exp_ccr.z = zero;
                exp_ccr.c = r.operand1[0];
                exp_ccr.v = 1'b0;
                if (r.op != ROR) begin
                    exp_ccr.x = r.operand1[0];
                end
            end
            default: ;
        endcase
        if (r.op != NOP && r.op != CMP) begin
            exp_result.long_word = res;
        end
    endtask

    // Model of a finished division, X untouched
    task automatic divide_model(input alu_req_t r);
        logic [HALF_W-1:0] divisor;
        longint            dividend;
        longint            dsor;
        longint            quo;
        longint            rem;
        logic              overflow;
        divisor   = r.operand2[HALF_W-1:0];
        exp_trap  = 1'b1;
        exp_ccr.z = 1'b0;
        exp_ccr.c = 1'b0;
        if (divisor == '0) begin
            exp_ccr.n = 1'b0;
            exp_ccr.v = 1'b0;
        end else begin
            if (r.div_signed) begin
                dividend = longint'($signed(r.operand1));
                dsor     = longint'($signed(divisor));
            end else begin
                dividend = longint'(r.operand1);
                dsor     = longint'(divisor);
            end
            quo = dividend / dsor;
            rem = dividend % dsor;
            if (r.div_signed) begin
                overflow = (quo > 32767) || (quo < -32768);
            end else begin
                overflow = quo > 65535;
            end
            if (overflow) begin
                exp_ccr.n = 1'b1;
                exp_ccr.v = 1'b1;
            end else begin
                exp_trap                 = 1'b0;
                exp_ccr.n                = quo[HALF_W-1];
                exp_ccr.z                = quo[HALF_W-1:0] == '0;
                exp_ccr.v                = 1'b0;
                exp_result.div.quotient  = quo[HALF_W-1:0];
                exp_result.div.remainder = rem[HALF_W-1:0];
            end
        end
    endtask

    task automatic run_op(input alu_req_t r);
        req = r;
        model_step(r);
        @(posedge clock);
        #5;
        check_outputs($sformatf("%s size %s", r.op.name(), r.size.name()));
    endtask

    // busy issues random operations while the divider iterates
    task automatic run_division(input alu_req_t r, input bit busy);
        int    steps;
        string what;
        what = $sformatf("%s %h/%h", r.div_signed ? "DIVS" : "DIVU", r.operand1,
                         r.operand2[HALF_W-1:0]);
        req = r;
        if (r.operand2[HALF_W-1:0] == '0) begin
            divide_model(r);
            @(posedge clock);
            #5;
            check_outputs(what);
            check_ready(what, div_ready, 1'b1);
        end else begin
            // Start edge changes no output
            @(posedge clock);
            #5;
            check_outputs(what);
            check_ready(what, div_ready, 1'b0);
            steps = 0;
            while (div_ready !== 1'b1) begin
                run_op(busy ? random_req() : make_req(NOP, BYTE, 1'b0, '0, '0));
                steps++;
            end
            if (steps != DIV_STEPS) begin
                abort_run($sformatf("MISMATCH at %0t: %s ready after %0d cycles, expected %0d",
                                    $time, what, steps, DIV_STEPS));
            end
            // Collect cycle
            req = r;
            divide_model(r);
            @(posedge clock);
            #5;
            check_outputs(what);
        end
    endtask

    initial begin
        alu_req_t          r;
        logic [DATA_W-1:0] dividend;
        req        = '0;
        exp_result = '0;
        exp_ccr    = '0;
        exp_trap   = 1'b0;
        void'($urandom(43968));
        @(posedge reset_n);
        check_outputs("reset");
        check_ready("reset", div_ready, 1'b1);

        for (int i = 0; i < RAND_OPS; i++) begin
            run_op(random_req());
        end

        // Multi-precision chains, Z may only be cleared
        run_op(make_req(ADD, LONG, 1'b0, 32'hFFFF_FFFF, 32'h0000_0001));
        run_op(make_req(ADDX, LONG, 1'b0, 32'hFFFF_FFFF, 32'h0000_0000));
        run_op(make_req(ADDX, LONG, 1'b0, 32'h0000_0001, 32'h0000_0001));
        run_op(make_req(ADDX, LONG, 1'b0, 32'h0000_0000, 32'h0000_0000));
        run_op(make_req(SUB, WORD, 1'b0, 32'h0000_0000, 32'h0000_0001));
        run_op(make_req(MOVE, BYTE, 1'b0, 32'h0000_0000, 32'h0000_0000));
        run_op(make_req(SUBX, BYTE, 1'b0, 32'h0000_0001, 32'h0000_0000));
        run_op(make_req(SUBX, BYTE, 1'b0, 32'h0000_0000, 32'h0000_0000));
        for (int i = 0; i < CHAIN_OPS - 8; i++) begin
            r = random_req();
            r.op = ($urandom_range(0, 1) == 0) ? ADDX : SUBX;
            run_op(r);
        end

        for (int op = int'(ASL); op <= int'(ROXR); op++) begin
            for (int s = 0; s < 3; s++) begin
                for (int n = 0; n < SHIFT_REPS; n++) begin
                    run_op(make_req(alu_op_e'(op), alu_size_e'(s), 1'b0, $urandom(), '0));
                end
            end
        end

        // Zero divisor, overflow and the signed range limits
        run_division(make_req(DIV, LONG, 1'b0, 32'h1234_5678, 32'hABCD_0000), 1'b0);
        run_division(make_req(DIV, LONG, 1'b0, 32'hFFFF_FFFF, 32'h0000_0001), 1'b0);
        run_division(make_req(DIV, LONG, 1'b1, 32'h8000_0000, 32'h0000_FFFF), 1'b1);
        run_division(make_req(DIV, LONG, 1'b1, 32'h0000_8000, 32'h0000_0001), 1'b0);
        run_division(make_req(DIV, LONG, 1'b1, 32'hFFFF_8000, 32'h0000_0001), 1'b1);

        for (int i = 0; i < RAND_DIVS; i++) begin
            r = make_req(DIV, LONG, 1'(i % 2), '0, $urandom());
            dividend = $urandom() >> $urandom_range(0, 20);
            if (r.div_signed && $urandom_range(0, 1) == 1) begin
                dividend = -dividend;
            end
            r.operand1 = dividend;
            r.operand2[HALF_W-1:0] = HALF_W'($urandom_range(1, 16'hFFFF));
            run_division(r, ($urandom_range(0, 1) == 1));
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock, 100 ns period, and active-low reset for three cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release shortly after the edge, in step with the other inputs
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #5 reset_n = 1'b1;
    end

endmodule
